//--- dbg_defines.svh
// Bus widths and the DMI register map, shared by RTL and testbench
// Only 32-bit word accesses are supported on the system bus
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// System bus
`define DBG_ADDR_W 32
`define DBG_DATA_W 32
`define DBG_BE_W   (`DBG_DATA_W / 8)

// DMI address width
`define DBG_DMI_AW 7

// System bus access registers
`define DBG_SBCS_ADDR    7'h38
`define DBG_SBADDR0_ADDR 7'h39
`define DBG_SBDATA0_ADDR 7'h3C

`endif

//--- dbg_pkg.sv
// Types shared by the DMI and SPI bridges
// DMI response status reuses the op codes, 0 is ok and 3 is busy
`include "dbg_defines.svh"

package dbg_pkg;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  // First byte of an SPI frame
  typedef enum logic [7:0] {
    SPI_CMD_WRITE = 8'h01,
    SPI_CMD_READ  = 8'h02
  } spi_cmd_e;

  typedef enum logic [1:0] {
    SBA_IDLE,
    SBA_REQUEST,
    SBA_WAIT_RVALID
  } sba_state_e;

  typedef enum logic [2:0] {
    SPI_CMD,
    SPI_ADDR,
    SPI_WDATA,
    SPI_BUS_REQ,
    SPI_BUS_WAIT,
    SPI_RDATA,
    SPI_DONE
  } spi_state_e;

  typedef struct packed {
    logic [`DBG_DATA_W-1:0] data;
    logic [1:0]             op;
  } dmi_resp_t;

endpackage

//--- obi_if.sv
// OBI link between one master and one slave
// No error, ID or user signals
`timescale 1ns/1ps
`include "dbg_defines.svh"

interface obi_if;

  logic                   req;
  logic                   gnt;
  logic [`DBG_ADDR_W-1:0] addr;
  logic                   we;
  logic [`DBG_BE_W-1:0]   be;
  logic [`DBG_DATA_W-1:0] wdata;
  logic                   rvalid;
  logic [`DBG_DATA_W-1:0] rdata;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- dmi_sba.sv
// DMI register file with RISC-V style system bus access, 32-bit words only
// Unaligned addresses set sberror to 3 and start no access
`timescale 1ns/1ps
`include "dbg_defines.svh"

module dmi_sba (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   dmi_req_valid_i,
  output logic                   dmi_req_ready_o,
  input  logic [`DBG_DMI_AW-1:0] dmi_req_addr_i,
  input  dbg_pkg::dmi_op_e       dmi_req_op_i,
  input  logic [`DBG_DATA_W-1:0] dmi_req_data_i,
  output logic                   dmi_resp_valid_o,
  input  logic                   dmi_resp_ready_i,
  output logic [`DBG_DATA_W-1:0] dmi_resp_data_o,
  output logic [1:0]             dmi_resp_op_o,
  obi_if.master                  bus_o
);

  localparam logic [1:0] STAT_BUSY = 2'h3;

  dbg_pkg::sba_state_e    state_q;
  dbg_pkg::dmi_resp_t     resp_q;
  logic                   resp_valid_q;
  logic                   sbbusyerror_q;
  logic                   sbreadonaddr_q;
  logic                   sbautoincrement_q;
  logic [2:0]             sberror_q;
  logic                   we_q;
  logic [`DBG_ADDR_W-1:0] sbaddress0_q;
  logic [`DBG_ADDR_W-1:0] bus_addr_q;
  logic [`DBG_DATA_W-1:0] sbdata0_q;
  logic [`DBG_DATA_W-1:0] sbcs;
  logic [`DBG_DATA_W-1:0] rd_data;
  logic [`DBG_ADDR_W-1:0] new_addr;
  logic                   sbbusy;
  logic                   req_fire;
  logic                   is_wr;
  logic                   is_rd;
  logic                   wr_sbcs;
  logic                   wr_sbaddr;
  logic                   wr_sbdata;
  logic                   rd_sbdata;
  logic                   start;
  logic                   busy_hit;

  assign sbbusy          = (state_q != dbg_pkg::SBA_IDLE);
  assign dmi_req_ready_o = ~resp_valid_q;
  assign req_fire        = dmi_req_valid_i & dmi_req_ready_o;
  assign is_wr           = req_fire & (dmi_req_op_i == dbg_pkg::DMI_WRITE);
  assign is_rd           = req_fire & (dmi_req_op_i == dbg_pkg::DMI_READ);
  assign wr_sbcs         = is_wr & (dmi_req_addr_i == `DBG_SBCS_ADDR);
  assign wr_sbaddr       = is_wr & (dmi_req_addr_i == `DBG_SBADDR0_ADDR);
  assign wr_sbdata       = is_wr & (dmi_req_addr_i == `DBG_SBDATA0_ADDR);
  assign rd_sbdata       = is_rd & (dmi_req_addr_i == `DBG_SBDATA0_ADDR);

  // Accesses that launch a bus transfer
  assign start    = wr_sbdata | (wr_sbaddr & sbreadonaddr_q);
  assign busy_hit = sbbusy & (start | rd_sbdata);
  assign new_addr = wr_sbaddr ? dmi_req_data_i : sbaddress0_q;

  always_comb begin
    sbcs          = '0;
    sbcs[31:29]   = 3'd1;
    sbcs[22]      = sbbusyerror_q;
    sbcs[21]      = sbbusy;
    sbcs[20]      = sbreadonaddr_q;
    // 32-bit access size
    sbcs[19:17]   = 3'd2;
    sbcs[16]      = sbautoincrement_q;
    sbcs[14:12]   = sberror_q;
    sbcs[11:5]    = 7'(`DBG_ADDR_W);
    sbcs[2]       = 1'b1;
  end

  always_comb begin
    case (dmi_req_addr_i)
      `DBG_SBCS_ADDR:    rd_data = sbcs;
      `DBG_SBADDR0_ADDR: rd_data = sbaddress0_q;
      `DBG_SBDATA0_ADDR: rd_data = sbdata0_q;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q           <= dbg_pkg::SBA_IDLE;
      resp_valid_q      <= 1'b0;
      sbbusyerror_q     <= 1'b0;
      sbreadonaddr_q    <= 1'b0;
      sbautoincrement_q <= 1'b0;
      sberror_q         <= 3'd0;
      we_q              <= 1'b0;
      sbaddress0_q      <= '0;
      sbdata0_q         <= '0;
    end else begin
      if (req_fire) begin
        resp_valid_q <= 1'b1;
      end else if (dmi_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end

      if (busy_hit) begin
        sbbusyerror_q <= 1'b1;
      end else begin
        if (wr_sbcs) begin
          // Write 1 to clear
          if (dmi_req_data_i[22]) begin
            sbbusyerror_q <= 1'b0;
          end
          sbreadonaddr_q    <= dmi_req_data_i[20];
          sbautoincrement_q <= dmi_req_data_i[16];
          sberror_q         <= sberror_q & ~dmi_req_data_i[14:12];
        end
        if (wr_sbaddr) begin
          sbaddress0_q <= dmi_req_data_i;
        end
        if (wr_sbdata) begin
          sbdata0_q <= dmi_req_data_i;
        end
        if (start) begin
          if (|new_addr[1:0]) begin
            sberror_q <= 3'd3;
          end else begin
            state_q <= dbg_pkg::SBA_REQUEST;
            we_q    <= wr_sbdata;
          end
        end
      end

      case (state_q)
        dbg_pkg::SBA_REQUEST: begin
          if (bus_o.gnt) begin
            state_q <= dbg_pkg::SBA_WAIT_RVALID;
          end
        end
        dbg_pkg::SBA_WAIT_RVALID: begin
          if (bus_o.rvalid) begin
            state_q <= dbg_pkg::SBA_IDLE;
            if (!we_q) begin
              sbdata0_q <= bus_o.rdata;
            end
            if (sbautoincrement_q) begin
              sbaddress0_q <= bus_addr_q + `DBG_ADDR_W'(4);
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.data <= (is_rd && !busy_hit) ? rd_data : '0;
      resp_q.op   <= busy_hit ? STAT_BUSY : dbg_pkg::DMI_NOP;
    end
    if (start && !busy_hit) begin
      bus_addr_q <= new_addr;
    end
  end

  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_data_o  = resp_q.data;
  assign dmi_resp_op_o    = resp_q.op;

  assign bus_o.req   = (state_q == dbg_pkg::SBA_REQUEST);
  assign bus_o.addr  = bus_addr_q;
  assign bus_o.we    = we_q;
  assign bus_o.be    = '1;
  assign bus_o.wdata = sbdata0_q;

endmodule

//--- spi_obi_bridge.sv
// SPI mode 0 slave issuing one OBI word access per frame, cs active low
// Pins are resynchronized to clk_i, so sck must be at most clk_i/8
// A bus read must complete within the 8 dummy sck periods of a read frame
`timescale 1ns/1ps
`include "dbg_defines.svh"

module spi_obi_bridge (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  spi_sck_i,
  input  logic  spi_cs_i,
  input  logic  spi_mosi_i,
  output logic  spi_miso_o,
  obi_if.master bus_o
);

  localparam int DUMMY_BITS = 8;
  localparam int FRAME_END  = DUMMY_BITS + `DBG_DATA_W;

  dbg_pkg::spi_state_e    state_q;
  logic [2:0]             sck_q;
  logic [1:0]             cs_q;
  logic [1:0]             mosi_q;
  logic [5:0]             cnt_q;
  logic [`DBG_DATA_W-1:0] sr_q;
  logic [`DBG_DATA_W-1:0] sr_next;
  logic [`DBG_ADDR_W-1:0] addr_q;
  logic [7:0]             cmd_byte;
  logic                   is_write_q;
  logic                   miso_q;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   bus_phase;
  logic                   shifting;
  logic                   addr_done;
  logic                   out_shift;

  // Two flops per pin, the third sck flop is for edge detection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck_i};
      cs_q   <= {cs_q[0], spi_cs_i};
      mosi_q <= {mosi_q[0], spi_mosi_i};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign sr_next   = {sr_q[`DBG_DATA_W-2:0], mosi_q[1]};
  assign cmd_byte  = sr_next[7:0];
  assign bus_phase = (state_q == dbg_pkg::SPI_BUS_REQ) | (state_q == dbg_pkg::SPI_BUS_WAIT);
  assign shifting  = ~cs_q[1] & ((state_q == dbg_pkg::SPI_CMD) |
                                 (state_q == dbg_pkg::SPI_ADDR) |
                                 (state_q == dbg_pkg::SPI_WDATA));
  assign addr_done = (state_q == dbg_pkg::SPI_ADDR) & sck_rise &
                     (cnt_q == 6'(`DBG_ADDR_W - 1));
  // Data bits leave on falling edges once the dummy bits have passed
  assign out_shift = ~cs_q[1] & (state_q == dbg_pkg::SPI_RDATA) & sck_fall &
                     (cnt_q >= 6'(DUMMY_BITS));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= dbg_pkg::SPI_CMD;
      cnt_q      <= '0;
      is_write_q <= 1'b0;
      miso_q     <= 1'b0;
    end else if (cs_q[1] && !bus_phase) begin
      // Deselect ends the frame, a bus access in flight still completes
      state_q <= dbg_pkg::SPI_CMD;
      cnt_q   <= '0;
      miso_q  <= 1'b0;
    end else begin
      if (sck_rise) begin
        cnt_q <= cnt_q + 6'd1;
      end
      if (out_shift) begin
        miso_q <= sr_q[`DBG_DATA_W-1];
      end
      case (state_q)
        dbg_pkg::SPI_CMD: begin
          if (sck_rise && cnt_q == 6'd7) begin
            cnt_q <= '0;
            if (cmd_byte == dbg_pkg::SPI_CMD_WRITE || cmd_byte == dbg_pkg::SPI_CMD_READ) begin
              state_q    <= dbg_pkg::SPI_ADDR;
              is_write_q <= (cmd_byte == dbg_pkg::SPI_CMD_WRITE);
            end else begin
              // Unknown command, wait for deselect
              state_q <= dbg_pkg::SPI_DONE;
            end
          end
        end
        dbg_pkg::SPI_ADDR: begin
          if (addr_done) begin
            cnt_q   <= '0;
            state_q <= is_write_q ? dbg_pkg::SPI_WDATA : dbg_pkg::SPI_BUS_REQ;
          end
        end
        dbg_pkg::SPI_WDATA: begin
          if (sck_rise && cnt_q == 6'(`DBG_DATA_W - 1)) begin
            state_q <= dbg_pkg::SPI_BUS_REQ;
          end
        end
        dbg_pkg::SPI_BUS_REQ: begin
          if (bus_o.gnt) begin
            state_q <= dbg_pkg::SPI_BUS_WAIT;
          end
        end
        dbg_pkg::SPI_BUS_WAIT: begin
          if (bus_o.rvalid) begin
            state_q <= is_write_q ? dbg_pkg::SPI_DONE : dbg_pkg::SPI_RDATA;
          end
        end
        dbg_pkg::SPI_RDATA: begin
          if (cnt_q == 6'(FRAME_END)) begin
            state_q <= dbg_pkg::SPI_DONE;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Shared shift register for command, write data and read data
  always_ff @(posedge clk_i) begin
    if (sck_rise && shifting) begin
      sr_q <= sr_next;
    end
    if (state_q == dbg_pkg::SPI_BUS_WAIT && bus_o.rvalid && !is_write_q) begin
      sr_q <= bus_o.rdata;
    end
    if (out_shift) begin
      sr_q <= {sr_q[`DBG_DATA_W-2:0], 1'b0};
    end
    if (addr_done) begin
      addr_q <= sr_next;
    end
  end

  assign spi_miso_o = miso_q;

  assign bus_o.req   = (state_q == dbg_pkg::SPI_BUS_REQ);
  assign bus_o.addr  = addr_q;
  assign bus_o.we    = is_write_q;
  assign bus_o.be    = '1;
  assign bus_o.wdata = sr_q;

endmodule

//--- obi_arb2.sv
// Round-robin two-to-one OBI arbiter with one transaction in flight
// A request held off by gnt keeps its slot until granted
`timescale 1ns/1ps
`include "dbg_defines.svh"

module obi_arb2 (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  obi_if.slave                   m0_i,
  obi_if.slave                   m1_i,
  output logic                   bus_req_o,
  output logic [`DBG_ADDR_W-1:0] bus_addr_o,
  output logic                   bus_we_o,
  output logic [`DBG_BE_W-1:0]   bus_be_o,
  output logic [`DBG_DATA_W-1:0] bus_wdata_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  logic [`DBG_DATA_W-1:0] bus_rdata_i
);

  logic last_q;
  logic owner_q;
  logic outstanding_q;
  logic lock_q;
  logic win;
  logic sel;

  // Tie goes to the master that lost last time
  assign win = (m0_i.req & m1_i.req) ? ~last_q : m1_i.req;
  assign sel = lock_q ? owner_q : win;

  assign bus_req_o   = ~outstanding_q & (sel ? m1_i.req : m0_i.req);
  assign bus_addr_o  = sel ? m1_i.addr : m0_i.addr;
  assign bus_we_o    = sel ? m1_i.we : m0_i.we;
  assign bus_be_o    = sel ? m1_i.be : m0_i.be;
  assign bus_wdata_o = sel ? m1_i.wdata : m0_i.wdata;

  assign m0_i.gnt = bus_req_o & ~sel & bus_gnt_i;
  assign m1_i.gnt = bus_req_o & sel & bus_gnt_i;

  assign m0_i.rvalid = outstanding_q & ~owner_q & bus_rvalid_i;
  assign m1_i.rvalid = outstanding_q & owner_q & bus_rvalid_i;
  assign m0_i.rdata  = owner_q ? '0 : bus_rdata_i;
  assign m1_i.rdata  = owner_q ? bus_rdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q        <= 1'b1;
      owner_q       <= 1'b0;
      outstanding_q <= 1'b0;
      lock_q        <= 1'b0;
    end else begin
      if (bus_req_o) begin
        owner_q <= sel;
        if (bus_gnt_i) begin
          outstanding_q <= 1'b1;
          last_q        <= sel;
          lock_q        <= 1'b0;
        end else begin
          lock_q <= 1'b1;
        end
      end
      if (outstanding_q && bus_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

endmodule

//--- debug_subsystem.sv
// Debug access subsystem, DMI and SPI bridges sharing one OBI master port
// DMI is driven directly, no JTAG TAP; SPI sck at most clk_i/8
`timescale 1ns/1ps
`include "dbg_defines.svh"

module debug_subsystem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // DMI
  input  logic                   dmi_req_valid_i,
  output logic                   dmi_req_ready_o,
  input  logic [`DBG_DMI_AW-1:0] dmi_req_addr_i,
  input  logic [1:0]             dmi_req_op_i,
  input  logic [`DBG_DATA_W-1:0] dmi_req_data_i,
  output logic                   dmi_resp_valid_o,
  input  logic                   dmi_resp_ready_i,
  output logic [`DBG_DATA_W-1:0] dmi_resp_data_o,
  output logic [1:0]             dmi_resp_op_o,

  // SPI slave
  input  logic                   spi_sck_i,
  input  logic                   spi_cs_i,
  input  logic                   spi_mosi_i,
  output logic                   spi_miso_o,

  // OBI master
  output logic                   bus_req_o,
  output logic [`DBG_ADDR_W-1:0] bus_addr_o,
  output logic                   bus_we_o,
  output logic [`DBG_BE_W-1:0]   bus_be_o,
  output logic [`DBG_DATA_W-1:0] bus_wdata_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  logic [`DBG_DATA_W-1:0] bus_rdata_i
);

  obi_if sba_bus ();
  obi_if spi_bus ();

  dmi_sba u_dmi_sba (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_addr_i   (dmi_req_addr_i),
    .dmi_req_op_i     (dbg_pkg::dmi_op_e'(dmi_req_op_i)),
    .dmi_req_data_i   (dmi_req_data_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .dmi_resp_op_o    (dmi_resp_op_o),
    .bus_o            (sba_bus.master)
  );

  spi_obi_bridge u_spi_bridge (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_sck_i  (spi_sck_i),
    .spi_cs_i   (spi_cs_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_miso_o (spi_miso_o),
    .bus_o      (spi_bus.master)
  );

  // DMI bridge on port 0, SPI bridge on port 1
  obi_arb2 u_arb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .m0_i         (sba_bus.slave),
    .m1_i         (spi_bus.slave),
    .bus_req_o    (bus_req_o),
    .bus_addr_o   (bus_addr_o),
    .bus_we_o     (bus_we_o),
    .bus_be_o     (bus_be_o),
    .bus_wdata_o  (bus_wdata_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i)
  );

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset, 20 ns period
// Reset is held low for two rising edges
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_checker.sv
// Watches the OBI port, matches bus writes against expected ones
// Writes may arrive in any order among those expected
`timescale 1ns/1ps

module tb_checker (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        bus_req_i,
  input logic        bus_gnt_i,
  input logic        bus_we_i,
  input logic [3:0]  bus_be_i,
  input logic [31:0] bus_addr_i,
  input logic [31:0] bus_wdata_i
);

  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  int          err_count = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        held_q = 1'b0;
  logic        held_we_q;
  logic [31:0] held_addr_q;
  logic [31:0] held_wdata_q;

  // Expected read data, zero where nothing was written
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
  endfunction

  function automatic int pending_writes();
    return exp_addr_q.size();
  endfunction

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    err_count++;
    test_errs++;
  endtask

  task automatic test_done(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  task automatic final_report();
    if (exp_addr_q.size() != 0) begin
      report_error("expected bus writes never appeared");
    end
    $display("tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
  endtask

  // Bus signals are stable mid cycle
  always @(negedge clk_i) begin
    int hit;
    hit = -1;
    if (rst_n_i && bus_req_i && bus_gnt_i && bus_we_i) begin
      check_value("bus write byte enables", 32'h0000_000F, {28'h0, bus_be_i});
      foreach (exp_addr_q[i]) begin
        if (hit < 0 && exp_addr_q[i] == bus_addr_i && exp_data_q[i] == bus_wdata_i) begin
          hit = i;
        end
      end
      if (hit >= 0) begin
        exp_addr_q.delete(hit);
        exp_data_q.delete(hit);
        ref_mem[bus_addr_i] = bus_wdata_i;
      end else if (exp_addr_q.size() == 0) begin
        report_error($sformatf("unexpected bus write to %h", bus_addr_i));
      end else begin
        $display("[FAIL] bus write: expected %h:%h, actual %h:%h",
                 exp_addr_q[0], exp_data_q[0], bus_addr_i, bus_wdata_i);
        err_count++;
        test_errs++;
      end
    end
  end

  // A request not granted must come back unchanged in the next cycle
  always @(negedge clk_i) begin
    if (rst_n_i && held_q) begin
      if (!bus_req_i || bus_we_i !== held_we_q || bus_addr_i !== held_addr_q ||
          bus_wdata_i !== held_wdata_q) begin
        report_error("bus request dropped or changed before gnt");
      end
    end
    held_q       = rst_n_i && bus_req_i && !bus_gnt_i;
    held_we_q    = bus_we_i;
    held_addr_q  = bus_addr_i;
    held_wdata_q = bus_wdata_i;
  end

endmodule

//--- tb_debug_subsystem.sv
// Testbench top: OBI memory with random wait states, DMI and SPI drivers
// Inputs change 2 ns after the rising edge, outputs are read there too
`timescale 1ns/1ps
`include "dbg_defines.svh"

module tb_debug_subsystem;

  localparam int NUM_TESTS    = 6;
  localparam int LIMIT_CYCLES = NUM_TESTS * 80 * 8 * 2 + 1000;
  localparam logic [31:0] RDONADDR = 32'h0010_0000;
  localparam logic [31:0] AUTOINC  = 32'h0001_0000;
  localparam logic [31:0] BUSYERR  = 32'h0040_0000;

  logic                   clk;
  logic                   rst_n;
  logic                   dmi_req_valid_i = 1'b0;
  logic                   dmi_req_ready_o;
  logic [`DBG_DMI_AW-1:0] dmi_req_addr_i = '0;
  logic [1:0]             dmi_req_op_i = '0;
  logic [31:0]            dmi_req_data_i = '0;
  logic                   dmi_resp_valid_o;
  logic                   dmi_resp_ready_i = 1'b1;
  logic [31:0]            dmi_resp_data_o;
  logic [1:0]             dmi_resp_op_o;
  logic                   spi_sck_i = 1'b0;
  logic                   spi_cs_i = 1'b1;
  logic                   spi_mosi_i = 1'b0;
  logic                   spi_miso_o;
  logic                   bus_req_o;
  logic [31:0]            bus_addr_o;
  logic                   bus_we_o;
  logic [3:0]             bus_be_o;
  logic [31:0]            bus_wdata_o;
  logic                   bus_gnt_i = 1'b0;
  logic                   bus_rvalid_i = 1'b0;
  logic [31:0]            bus_rdata_i = '0;
  integer                 seed = 32'h6154_d91b;
  logic [31:0]            mem [logic [31:0]];
  logic [31:0]            rd;
  logic [31:0]            spi_rd;
  logic [1:0]             st;

  tb_clkgen clkgen (.clk_o(clk), .rst_n_o(rst_n));

  debug_subsystem dut0 (
    .clk_i(clk), .rst_n_i(rst_n),
    .dmi_req_valid_i(dmi_req_valid_i), .dmi_req_ready_o(dmi_req_ready_o),
    .dmi_req_addr_i(dmi_req_addr_i), .dmi_req_op_i(dmi_req_op_i),
    .dmi_req_data_i(dmi_req_data_i), .dmi_resp_valid_o(dmi_resp_valid_o),
    .dmi_resp_ready_i(dmi_resp_ready_i), .dmi_resp_data_o(dmi_resp_data_o),
    .dmi_resp_op_o(dmi_resp_op_o),
    .spi_sck_i(spi_sck_i), .spi_cs_i(spi_cs_i), .spi_mosi_i(spi_mosi_i),
    .spi_miso_o(spi_miso_o),
    .bus_req_o(bus_req_o), .bus_addr_o(bus_addr_o), .bus_we_o(bus_we_o),
    .bus_be_o(bus_be_o), .bus_wdata_o(bus_wdata_o), .bus_gnt_i(bus_gnt_i),
    .bus_rvalid_i(bus_rvalid_i), .bus_rdata_i(bus_rdata_i)
  );

  tb_checker chk (
    .clk_i(clk), .rst_n_i(rst_n), .bus_req_i(bus_req_o), .bus_gnt_i(bus_gnt_i),
    .bus_we_i(bus_we_o), .bus_be_i(bus_be_o), .bus_addr_i(bus_addr_o),
    .bus_wdata_i(bus_wdata_o)
  );

  // Memory model, gnt after 0 to 3 cycles, rvalid 1 to 3 cycles after gnt
  initial begin
    int          gnt_wait;
    int          rv_wait;
    logic        pend;
    logic [31:0] rd_word;
    gnt_wait = -1;
    rv_wait  = 0;
    pend     = 1'b0;
    rd_word  = '0;
    forever begin
      @(posedge clk);
      #2;
      bus_gnt_i    = 1'b0;
      bus_rvalid_i = 1'b0;
      if (pend) begin
        if (rv_wait == 0) begin
          bus_rvalid_i = 1'b1;
          bus_rdata_i  = rd_word;
          pend         = 1'b0;
        end else begin
          rv_wait--;
        end
      end else if (bus_req_o) begin
        if (gnt_wait < 0) begin
          gnt_wait = $unsigned($random(seed)) % 4;
        end
        if (gnt_wait == 0) begin
          bus_gnt_i = 1'b1;
          gnt_wait  = -1;
          pend      = 1'b1;
          rv_wait   = $unsigned($random(seed)) % 3;
          if (bus_we_o) begin
            mem[bus_addr_o] = bus_wdata_o;
          end
          rd_word = mem.exists(bus_addr_o) ? mem[bus_addr_o] : 32'h0;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  // Called and returns 2 ns after a rising edge
  task automatic dmi_access(input logic [6:0] addr, input logic [1:0] op,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic [1:0] status);
    dmi_req_valid_i = 1'b1;
    dmi_req_addr_i  = addr;
    dmi_req_op_i    = op;
    dmi_req_data_i  = wdata;
    while (!dmi_req_ready_o) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    dmi_req_valid_i = 1'b0;
    while (!dmi_resp_valid_o) begin
      @(posedge clk);
      #2;
    end
    rdata  = dmi_resp_data_o;
    status = dmi_resp_op_o;
    @(posedge clk);
    #2;
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic [1:0]  status;
    dmi_access(addr, dbg_pkg::DMI_WRITE, data, unused, status);
    chk.check_value("dmi write status", 32'h0, {30'h0, status});
  endtask

  task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
    logic [1:0] status;
    dmi_access(addr, dbg_pkg::DMI_READ, 32'h0, data, status);
    chk.check_value("dmi read status", 32'h0, {30'h0, status});
  endtask

  task automatic wait_not_busy();
    logic [31:0] cs;
    int          polls;
    cs    = 32'h0020_0000;
    polls = 0;
    while (cs[21] && polls < 200) begin
      dmi_read(`DBG_SBCS_ADDR, cs);
      polls++;
    end
    if (cs[21]) begin
      chk.report_error("sbbusy did not clear");
    end
  endtask

  task automatic wait_writes_done();
    int cycles;
    cycles = 0;
    while (chk.pending_writes() != 0 && cycles < 2000) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (chk.pending_writes() != 0) begin
      chk.report_error("expected bus write did not appear");
    end
  endtask

  // Returns 2 ns after the first rising edge that shows a bus request
  task automatic wait_bus_req();
    int cycles;
    cycles = 0;
    while (!bus_req_o && cycles < 2000) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!bus_req_o) begin
      chk.report_error("no bus request appeared");
    end
  endtask

  // Mode 0, sck period of 8 clocks, miso read just before each rising edge
  task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [79:0] tx;
    logic [79:0] rx;
    int          nbits;
    logic        b;
    nbits = (cmd == dbg_pkg::SPI_CMD_WRITE) ? 72 : 80;
    tx    = (nbits == 72) ? {cmd, addr, wdata, 8'h0} : {cmd, addr, 40'h0};
    rx    = '0;
    spi_cs_i = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    for (int i = 0; i < nbits; i++) begin
      spi_mosi_i = tx[79 - i];
      repeat (4) @(posedge clk);
      #2;
      b  = spi_miso_o;
      rx = {rx[78:0], b};
      spi_sck_i = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      spi_sck_i = 1'b0;
    end
    repeat (4) @(posedge clk);
    #2;
    spi_cs_i = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rdata = rx[31:0];
  endtask

  initial begin
    wait (rst_n === 1'b1);
    @(posedge clk);
    #2;

    // DMI write, then read back on address
    dmi_write(`DBG_SBCS_ADDR, 32'h0);
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_1000);
    chk.expect_write(32'h0000_1000, 32'hCAFE_0001);
    dmi_write(`DBG_SBDATA0_ADDR, 32'hCAFE_0001);
    wait_not_busy();
    dmi_write(`DBG_SBCS_ADDR, RDONADDR);
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_1000);
    wait_not_busy();
    dmi_read(`DBG_SBDATA0_ADDR, rd);
    chk.check_value("dmi readback", chk.ref_read(32'h0000_1000), rd);
    wait_writes_done();
    chk.test_done("dmi_write_read");

    // Auto increment over three writes
    dmi_write(`DBG_SBCS_ADDR, AUTOINC);
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_2000);
    for (int i = 0; i < 3; i++) begin
      chk.expect_write(32'h0000_2000 + 32'(4 * i), 32'h5A00_0000 + 32'(i));
      dmi_write(`DBG_SBDATA0_ADDR, 32'h5A00_0000 + 32'(i));
      wait_not_busy();
    end
    wait_writes_done();
    dmi_read(`DBG_SBADDR0_ADDR, rd);
    chk.check_value("autoinc address", 32'h0000_200C, rd);
    chk.test_done("dmi_autoincrement");

    // SPI write, DMI read back
    chk.expect_write(32'h0000_3000, 32'h1234_5678);
    spi_frame(dbg_pkg::SPI_CMD_WRITE, 32'h0000_3000, 32'h1234_5678, spi_rd);
    wait_writes_done();
    dmi_write(`DBG_SBCS_ADDR, RDONADDR);
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_3000);
    wait_not_busy();
    dmi_read(`DBG_SBDATA0_ADDR, rd);
    chk.check_value("spi write readback", chk.ref_read(32'h0000_3000), rd);
    chk.test_done("spi_write");

    // DMI write, SPI read back
    dmi_write(`DBG_SBCS_ADDR, 32'h0);
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_4000);
    chk.expect_write(32'h0000_4000, 32'h8765_4321);
    dmi_write(`DBG_SBDATA0_ADDR, 32'h8765_4321);
    wait_not_busy();
    wait_writes_done();
    spi_frame(dbg_pkg::SPI_CMD_READ, 32'h0000_4000, 32'h0, spi_rd);
    chk.check_value("spi read data", chk.ref_read(32'h0000_4000), spi_rd);
    chk.test_done("spi_read");

    // Both bridges at once
    chk.expect_write(32'h0000_5000, 32'hAAAA_5555);
    chk.expect_write(32'h0000_6000, 32'h0F0F_F0F0);
    fork
      begin
        dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_5000);
        // DMI write lands while the SPI write holds the bus
        wait_bus_req();
        dmi_write(`DBG_SBDATA0_ADDR, 32'hAAAA_5555);
        wait_not_busy();
      end
      begin
        spi_frame(dbg_pkg::SPI_CMD_WRITE, 32'h0000_6000, 32'h0F0F_F0F0, spi_rd);
      end
    join
    wait_writes_done();
    chk.test_done("concurrent_access");

    // Busy error on a second write
    dmi_write(`DBG_SBADDR0_ADDR, 32'h0000_7000);
    chk.expect_write(32'h0000_7000, 32'h7777_0001);
    dmi_write(`DBG_SBDATA0_ADDR, 32'h7777_0001);
    dmi_access(`DBG_SBDATA0_ADDR, dbg_pkg::DMI_WRITE, 32'h7777_0002, rd, st);
    chk.check_value("busy status", 32'h3, {30'h0, st});
    dmi_read(`DBG_SBCS_ADDR, rd);
    chk.check_value("sbbusyerror set", 32'h1, {31'h0, rd[22]});
    wait_not_busy();
    wait_writes_done();
    dmi_write(`DBG_SBCS_ADDR, BUSYERR);
    dmi_read(`DBG_SBCS_ADDR, rd);
    chk.check_value("sbbusyerror cleared", 32'h0, {31'h0, rd[22]});
    repeat (20) @(posedge clk);
    #2;
    chk.test_done("busy_error");

    chk.final_report();
    if (chk.err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
dbg_pkg.sv
obi_if.sv
dmi_sba.sv
spi_obi_bridge.sv
obi_arb2.sv
debug_subsystem.sv
tb_clkgen.sv
tb_checker.sv
tb_debug_subsystem.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check run.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -f all.f --top-module tb_debug_subsystem -o sim
	./obj_dir/sim > run.log 2>&1 || true
	@cat run.log
	@grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log
